// ==== hdl/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // wishbone classic slave port widths
    localparam int WB_ADR_W = 32;              // byte address
    localparam int WB_DAT_W = 32;              // read and write data
    localparam int WB_SEL_W = WB_DAT_W / 8;    // one select per byte

    // the register index sits in the word offset bits of the address
    localparam int REG_ADR_LSB = 2;            // 32-bit words
    localparam int REG_ADR_W   = 4;            // address bits 5:2

    // register map, value equals the word offset
    typedef enum logic [REG_ADR_W-1:0] {
        REG_LED     = 4'd0,                    // rw, byte 0 only
        REG_DIP     = 4'd1,                    // ro, dip switches
        REG_BTN     = 4'd2,                    // ro, push buttons
        REG_AUDIO_L = 4'd3,                    // wo, left sample holding reg
        REG_AUDIO_R = 4'd4,                    // wo, right sample, pushes frame
        REG_STATUS  = 4'd5,                    // ro, fifo flags
        REG_NONE    = 4'd15                    // any other offset
    } reg_sel_e;

    // status word bit positions
    localparam int STAT_FULL_BIT  = 0;         // frame fifo full
    localparam int STAT_EMPTY_BIT = 1;         // frame fifo empty

    // board i/o widths
    localparam int LED_W = 8;                  // leds
    localparam int DIP_W = 8;                  // dip switches
    localparam int BTN_W = 5;                  // c, d, l, r, u buttons

endpackage

`default_nettype wire

// ==== hdl/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // one dac sample, two's complement
    localparam int SAMPLE_W = 24;

    // stereo frame, left in the upper half
    localparam int FRAME_W = 2 * SAMPLE_W;

    // bclk periods per channel slot
    localparam int SLOT_W = 32;

    // bit counter inside one slot
    localparam int SLOT_CNT_W = $clog2(SLOT_W);

    // zero padding behind the sample in a slot
    localparam int PAD_W = SLOT_W - SAMPLE_W;

    // i2s transmitter sequence
    typedef enum logic [1:0] {
        IDLE_LOAD,                             // waiting for the first slot start
        SHIFT_L,                               // left slot, lrclk low
        SHIFT_R                                // right slot, lrclk high
    } i2s_state_e;

endpackage

`default_nettype wire

// ==== hdl/reset_stretch.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
    parameter int RESET_CYCLES = 32            // hold time after button release
) (
    input  wire  clk_soc,
    input  wire  btn_rst,                      // raw button, active high
    output logic sys_rst_o                     // stretched reset for the subsystem
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;                // remaining hold edges

    always_ff @(posedge clk_soc) begin
        if (btn_rst) begin
            hold_cnt <= CNT_W'(RESET_CYCLES);  // reload while pressed
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;       // count down after release
        end
    end

    // the button acts at once, the counter keeps it up afterwards
    // so the first edge with btn_rst low still sees a full count
    always_comb begin
        sys_rst_o = btn_rst || (hold_cnt != '0);
    end

endmodule

`default_nettype wire

// ==== hdl/wishbone_bus_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module wishbone_bus_logic (
    input  wire                                 clk_soc,
    input  wire                                 rst_i,
    input  wire                                 wb_cyc_i,
    input  wire                                 wb_stb_i,
    input  wire                                 wb_we_i,
    input  wire  [soc_bus_pkg::WB_ADR_W-1:0]    wb_adr_i,
    input  wire  [soc_bus_pkg::WB_DAT_W-1:0]    wb_dat_i,
    input  wire  [soc_bus_pkg::WB_SEL_W-1:0]    wb_sel_i,
    input  wire  [soc_bus_pkg::DIP_W-1:0]       dip_i,
    input  wire  [soc_bus_pkg::BTN_W-1:0]       btn_i,
    input  wire                                 fifo_full_i,
    input  wire                                 fifo_empty_i,
    output logic [soc_bus_pkg::WB_DAT_W-1:0]    wb_dat_o,
    output logic                                wb_ack_o,
    output logic [soc_bus_pkg::LED_W-1:0]       led_o,
    output logic                                fifo_wr_o,
    output logic [audio_pkg::FRAME_W-1:0]       fifo_frame_o
);

    soc_bus_pkg::reg_sel_e                 reg_sel;     // decoded register
    logic                                  req;         // new request this cycle
    logic                                  push_req;    // right sample write
    logic                                  push_go;     // push allowed now
    logic [soc_bus_pkg::WB_DAT_W-1:0]      rd_mux;      // read value of reg_sel
    logic [soc_bus_pkg::WB_DAT_W-1:0]      rd_data_q;   // returned in ack cycle
    logic                                  ack_q;
    logic                                  fifo_wr_q;
    logic [soc_bus_pkg::LED_W-1:0]         led_q;
    logic [soc_bus_pkg::DIP_W-1:0]         dip_q;       // sampled switches
    logic [soc_bus_pkg::BTN_W-1:0]         btn_q;       // sampled buttons
    logic [audio_pkg::SAMPLE_W-1:0]        left_q;      // left holding reg
    logic [audio_pkg::SAMPLE_W-1:0]        right_q;     // right half of pushed frame

    // byte-masked update of a sample, only the low three selects apply
    function automatic logic [audio_pkg::SAMPLE_W-1:0] merge_sample(
        input logic [audio_pkg::SAMPLE_W-1:0]   old_v,
        input logic [soc_bus_pkg::WB_DAT_W-1:0] dat,
        input logic [soc_bus_pkg::WB_SEL_W-1:0] sel
    );
        logic [audio_pkg::SAMPLE_W-1:0] res;
        res = old_v;
        for (int b = 0; b < audio_pkg::SAMPLE_W / 8; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        if (wb_adr_i[soc_bus_pkg::REG_ADR_LSB +: soc_bus_pkg::REG_ADR_W] <= 4'd5) begin
            reg_sel = soc_bus_pkg::reg_sel_e'(
                wb_adr_i[soc_bus_pkg::REG_ADR_LSB +: soc_bus_pkg::REG_ADR_W]);
        end else begin
            reg_sel = soc_bus_pkg::REG_NONE;    // unmapped, reads zero
        end
    end

    assign req      = wb_cyc_i && wb_stb_i && !ack_q;   // ack cycle is not a new request
    assign push_req = req && wb_we_i && (reg_sel == soc_bus_pkg::REG_AUDIO_R);
    assign push_go  = push_req && !fifo_full_i;         // stall while full

    always_comb begin
        rd_mux = '0;                                    // write-only and unmapped read 0
        case (reg_sel)
            soc_bus_pkg::REG_LED:    rd_mux[soc_bus_pkg::LED_W-1:0] = led_q;
            soc_bus_pkg::REG_DIP:    rd_mux[soc_bus_pkg::DIP_W-1:0] = dip_q;
            soc_bus_pkg::REG_BTN:    rd_mux[soc_bus_pkg::BTN_W-1:0] = btn_q;
            soc_bus_pkg::REG_STATUS: begin
                rd_mux[soc_bus_pkg::STAT_FULL_BIT]  = fifo_full_i;
                rd_mux[soc_bus_pkg::STAT_EMPTY_BIT] = fifo_empty_i;
            end
            default: ;
        endcase
    end

    // control state, ack lands one edge after the request is seen
    always_ff @(posedge clk_soc) begin
        if (rst_i) begin
            ack_q     <= 1'b0;
            fifo_wr_q <= 1'b0;
            led_q     <= '0;
        end else begin
            ack_q     <= 1'b0;                          // single-cycle pulses
            fifo_wr_q <= 1'b0;
            if (req && (!push_req || push_go)) begin
                ack_q <= 1'b1;                          // push waits for room
            end
            if (push_go) begin
                fifo_wr_q <= 1'b1;                      // frame enters fifo with the ack
            end
            if (req && wb_we_i && (reg_sel == soc_bus_pkg::REG_LED) && wb_sel_i[0]) begin
                led_q <= wb_dat_i[soc_bus_pkg::LED_W-1:0];
            end
        end
    end

    // data path
    always_ff @(posedge clk_soc) begin
        dip_q <= dip_i;                                 // one sample per cycle
        btn_q <= btn_i;
        if (req && wb_we_i && (reg_sel == soc_bus_pkg::REG_AUDIO_L)) begin
            left_q <= merge_sample(left_q, wb_dat_i, wb_sel_i);
        end
        if (push_go) begin
            right_q <= merge_sample(right_q, wb_dat_i, wb_sel_i);
        end
        if (req) begin
            rd_data_q <= wb_we_i ? '0 : rd_mux;         // writes return zero
        end
    end

    assign wb_ack_o     = ack_q;
    assign wb_dat_o     = rd_data_q;
    assign led_o        = led_q;
    assign fifo_wr_o    = fifo_wr_q;
    assign fifo_frame_o = {left_q, right_q};            // left in the upper half

endmodule

`default_nettype wire

// ==== hdl/audio_frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_frame_fifo #(
    parameter int FIFO_DEPTH = 4               // frames, power of two
) (
    input  wire                              clk_soc,
    input  wire                              rst_i,
    input  wire                              wr_i,          // push on this edge
    input  wire  [audio_pkg::FRAME_W-1:0]    wr_frame_i,
    input  wire                              take_i,        // pop the head frame
    output logic [audio_pkg::FRAME_W-1:0]    rd_frame_o,    // head, falls through
    output logic                             full_o,
    output logic                             empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [audio_pkg::FRAME_W-1:0] mem [FIFO_DEPTH];   // frame storage
    logic [AW:0]                   wr_ptr;             // extra msb marks the lap
    logic [AW:0]                   rd_ptr;
    logic                          do_wr;
    logic                          do_rd;

    // same index, different lap -> full; same lap -> empty
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty_o = (wr_ptr == rd_ptr);

    assign do_wr = wr_i && !full_o;            // writer never pushes when full
    assign do_rd = take_i && !empty_o;

    always_ff @(posedge clk_soc) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_soc) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_frame_i;
        end
    end

    // head entry straight out, visible the cycle after the push
    assign rd_frame_o = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// ==== hdl/i2s_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_master #(
    parameter int BCLK_DIV = 4                 // clk_soc cycles per bclk half
) (
    input  wire                              clk_soc,
    input  wire                              rst_i,
    input  wire  [audio_pkg::FRAME_W-1:0]    frame_i,        // fifo head
    input  wire                              frame_valid_i,  // fifo not empty
    output logic                             take_o,         // one-cycle pop
    output logic                             ac_mclk_o,
    output logic                             ac_bclk_o,
    output logic                             ac_lrclk_o,
    output logic                             ac_dac_sdata_o
);

    localparam int DIV_W = $clog2(BCLK_DIV + 1);

    audio_pkg::i2s_state_e              state;
    logic [DIV_W-1:0]                   div_cnt;      // clk_soc cycles in bclk half
    logic                               div_wrap;
    logic                               bclk_fall;    // bclk goes low on this edge
    logic                               slot_end;     // last bit of the slot
    logic [audio_pkg::SLOT_CNT_W-1:0]   bit_cnt;
    logic [audio_pkg::SLOT_W-1:0]       shift_q;      // msb goes out next
    logic [audio_pkg::SAMPLE_W-1:0]     right_q;      // right half of current frame
    logic                               mclk_q;
    logic                               bclk_q;
    logic                               lrclk_q;
    logic                               sdata_q;
    logic                               take_q;

    assign div_wrap  = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign bclk_fall = div_wrap && bclk_q;
    assign slot_end  = (bit_cnt == audio_pkg::SLOT_CNT_W'(audio_pkg::SLOT_W - 1));

    always_ff @(posedge clk_soc) begin
        if (rst_i) begin
            mclk_q  <= 1'b0;
            bclk_q  <= 1'b0;
            div_cnt <= '0;
        end else begin
            mclk_q <= ~mclk_q;                        // clk_soc / 2
            if (div_wrap) begin
                div_cnt <= '0;
                bclk_q  <= ~bclk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // data and lrclk move on the same edge that takes bclk low
    always_ff @(posedge clk_soc) begin
        if (rst_i) begin
            state   <= audio_pkg::IDLE_LOAD;
            bit_cnt <= '0;
            lrclk_q <= 1'b0;
            sdata_q <= 1'b0;
            take_q  <= 1'b0;
            shift_q <= '0;
            right_q <= '0;
        end else begin
            take_q <= 1'b0;
            if (bclk_fall) begin
                sdata_q <= shift_q[audio_pkg::SLOT_W-1];  // last bit of old slot at boundary
                shift_q <= shift_q << 1;
                bit_cnt <= bit_cnt + 1'b1;
                if (state == audio_pkg::IDLE_LOAD || (state == audio_pkg::SHIFT_R && slot_end)) begin
                    state   <= audio_pkg::SHIFT_L;        // left slot start takes a frame
                    lrclk_q <= 1'b0;
                    bit_cnt <= '0;
                    take_q  <= frame_valid_i;             // no pop on underflow
                    if (frame_valid_i) begin
                        shift_q <= {frame_i[audio_pkg::FRAME_W-1 -: audio_pkg::SAMPLE_W],
                                    {audio_pkg::PAD_W{1'b0}}};
                        right_q <= frame_i[audio_pkg::SAMPLE_W-1:0];
                    end else begin
                        shift_q <= '0;                    // silent frame
                        right_q <= '0;
                    end
                end else if (state == audio_pkg::SHIFT_L && slot_end) begin
                    state   <= audio_pkg::SHIFT_R;
                    lrclk_q <= 1'b1;                      // right slot
                    bit_cnt <= '0;
                    shift_q <= {right_q, {audio_pkg::PAD_W{1'b0}}};
                end
            end
        end
    end

    assign take_o         = take_q;
    assign ac_mclk_o      = mclk_q;
    assign ac_bclk_o      = bclk_q;
    assign ac_lrclk_o     = lrclk_q;
    assign ac_dac_sdata_o = sdata_q;

endmodule

`default_nettype wire

// ==== hdl/audio_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_periph_top #(
    parameter int RESET_CYCLES = 32,           // reset hold after release
    parameter int FIFO_DEPTH   = 4,            // frames
    parameter int BCLK_DIV     = 4             // clk_soc cycles per bclk half
) (
    input  wire                                 clk_soc,
    input  wire                                 btn_rst,
    input  wire                                 wb_cyc_i,
    input  wire                                 wb_stb_i,
    input  wire                                 wb_we_i,
    input  wire  [soc_bus_pkg::WB_ADR_W-1:0]    wb_adr_i,
    input  wire  [soc_bus_pkg::WB_DAT_W-1:0]    wb_dat_i,
    input  wire  [soc_bus_pkg::WB_SEL_W-1:0]    wb_sel_i,
    input  wire  [soc_bus_pkg::DIP_W-1:0]       dip_i,
    input  wire  [soc_bus_pkg::BTN_W-1:0]       btn_i,
    output logic [soc_bus_pkg::WB_DAT_W-1:0]    wb_dat_o,
    output logic                                wb_ack_o,
    output logic [soc_bus_pkg::LED_W-1:0]       led_o,
    output logic                                ac_mclk_o,
    output logic                                ac_bclk_o,
    output logic                                ac_lrclk_o,
    output logic                                ac_dac_sdata_o
);

    logic                           sys_rst;      // stretched reset
    logic                           fifo_wr;
    logic [audio_pkg::FRAME_W-1:0]  fifo_frame;   // bus side frame
    logic                           fifo_full;
    logic                           fifo_empty;
    logic [audio_pkg::FRAME_W-1:0]  rd_frame;     // head frame to i2s
    logic                           rd_take;

    reset_stretch #(.RESET_CYCLES(RESET_CYCLES)) u_rst (
        .clk_soc   (clk_soc),
        .btn_rst   (btn_rst),
        .sys_rst_o (sys_rst)
    );

    wishbone_bus_logic u_bus (
        .clk_soc      (clk_soc),
        .rst_i        (sys_rst),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .dip_i        (dip_i),
        .btn_i        (btn_i),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .led_o        (led_o),
        .fifo_wr_o    (fifo_wr),
        .fifo_frame_o (fifo_frame)
    );

    audio_frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_soc    (clk_soc),
        .rst_i      (sys_rst),
        .wr_i       (fifo_wr),
        .wr_frame_i (fifo_frame),
        .take_i     (rd_take),
        .rd_frame_o (rd_frame),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty)
    );

    i2s_master #(.BCLK_DIV(BCLK_DIV)) u_i2s (
        .clk_soc        (clk_soc),
        .rst_i          (sys_rst),
        .frame_i        (rd_frame),
        .frame_valid_i  (!fifo_empty),            // valid whenever a frame is queued
        .take_o         (rd_take),
        .ac_mclk_o      (ac_mclk_o),
        .ac_bclk_o      (ac_bclk_o),
        .ac_lrclk_o     (ac_lrclk_o),
        .ac_dac_sdata_o (ac_dac_sdata_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o                         // 50 MHz soc clock
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;            // 20 ns period
    end

endmodule

`default_nettype wire

// ==== sim/audio_periph_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_periph_assert (
    input wire clk_soc,
    input wire rst_i,
    input wire wb_cyc_i,
    input wire wb_stb_i,
    input wire wb_ack_i,                       // slave ack
    input wire fifo_wr_i,                      // bus side push
    input wire fifo_full_i,
    input wire bclk_i,
    input wire lrclk_i
);

    // ack only inside an active request
    ack_in_cycle: assert property (@(posedge clk_soc) disable iff (rst_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o high without cyc and stb");

    // one ack per request
    ack_single: assert property (@(posedge clk_soc) disable iff (rst_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("wb_ack_o high for two cycles in a row");

    // word clock moves together with the bclk falling edge
    lrclk_on_fall: assert property (@(posedge clk_soc) disable iff (rst_i)
        $changed(lrclk_i) |-> $fell(bclk_i))
        else $error("lrclk changed away from a bclk falling edge");

    push_room: assert property (@(posedge clk_soc) disable iff (rst_i)
        fifo_wr_i |-> !fifo_full_i)
        else $error("fifo write while full");

endmodule

`default_nettype wire

// ==== sim/tb_audio_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_audio_periph;

    localparam int RESET_CYCLES = 32;
    localparam int FIFO_DEPTH   = 4;
    localparam int BCLK_DIV     = 4;
    localparam int FRAME_CYC    = 4 * BCLK_DIV * audio_pkg::SLOT_W;  // clk_soc per stereo frame
    localparam int CYCLE_LIMIT  = 4 * (24 * FRAME_CYC + 2000);       // frames plus bus traffic

    logic        clk_soc;
    logic        btn_rst;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [3:0]  wb_sel_i;
    logic [7:0]  dip_i;
    logic [4:0]  btn_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [7:0]  led_o;
    logic        ac_mclk_o;
    logic        ac_bclk_o;
    logic        ac_lrclk_o;
    logic        ac_dac_sdata_o;

    logic [47:0] exp_q[$];                     // frames written, in order
    logic [31:0] rng = 32'hb6b8150d;
    logic [7:0]  led_m;                        // register model
    logic [7:0]  dip_m;
    logic [4:0]  btn_m;
    logic        exp_full;
    logic        exp_empty;
    int          cycle_cnt = 0;
    int          frames_rx = 0;
    int          zero_frames = 0;              // underflow slots seen
    int          pos = 0;                      // bit position in slot
    logic        bclk_prev = 1'b0;
    logic        mclk_prev = 1'b0;
    logic        lr_prev = 1'b0;
    logic        synced = 1'b0;
    logic        rx_en = 1'b0;
    logic [23:0] left_rx = '0;
    logic [23:0] cur_sample = '0;

    tb_clock_gen u_clk (.clk_o(clk_soc));

    audio_periph_top #(
        .RESET_CYCLES(RESET_CYCLES),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .BCLK_DIV    (BCLK_DIV)
    ) uut (.*);

    bind audio_periph_top audio_periph_assert u_assert (
        .clk_soc(clk_soc), .rst_i(sys_rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
        .wb_ack_i(wb_ack_o), .fifo_wr_i(fifo_wr), .fifo_full_i(fifo_full),
        .bclk_i(ac_bclk_o), .lrclk_i(ac_lrclk_o)
    );

    task automatic fail_stop();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift(rng);
        v   = rng;
    endtask

    // expected read value from what was written or driven
    function automatic logic [31:0] ref_read(input logic [3:0] idx);
        case (idx)
            soc_bus_pkg::REG_LED:    return {24'h0, led_m};
            soc_bus_pkg::REG_DIP:    return {24'h0, dip_m};
            soc_bus_pkg::REG_BTN:    return {27'h0, btn_m};
            soc_bus_pkg::REG_STATUS: return {30'h0, exp_empty, exp_full};
            default:                 return 32'h0;     // write-only and unmapped
        endcase
    endfunction

    // one classic cycle, held until ack is seen
    task automatic wb_access(input logic we, input logic [3:0] idx, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdat, output int lat);
        @(posedge clk_soc);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= {26'h0, idx, 2'b00};
        wb_dat_i <= dat;
        wb_sel_i <= sel;
        lat = 0;
        do begin
            @(posedge clk_soc);
            lat++;
        end while (!wb_ack_o);
        rdat = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic read_check(input logic [3:0] idx);
        logic [31:0] got;
        logic [31:0] exp;
        int          lat;
        exp = ref_read(idx);
        wb_access(1'b0, idx, 32'h0, 4'h0, got, lat);
        assert (got == exp) else begin
            $display("FAILED wb_dat_o reg %0d: got %h expected %h", idx, got, exp);
            fail_stop();
        end
    endtask

    task automatic send_frame(output int lat);
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] rd;
        next_rand(l);
        next_rand(r);
        if (l[23:0] == 24'h0) l = 32'h1;             // zero frames mean underflow
        wb_access(1'b1, soc_bus_pkg::REG_AUDIO_L, l, 4'hf, rd, lat);
        wb_access(1'b1, soc_bus_pkg::REG_AUDIO_R, r, 4'hf, rd, lat);
        exp_q.push_back({l[23:0], r[23:0]});
    endtask

    task automatic check_frame(input logic [47:0] frame);
        if (frame == 48'h0) begin
            zero_frames++;                           // silent slot pair
        end else begin
            assert (exp_q.size() > 0) else begin
                $display("frame %h arrived although none was written", frame);
                fail_stop();
            end
            assert (frame == exp_q[0]) else begin
                $display("FAILED ac_dac_sdata_o frame: got %h expected %h", frame, exp_q[0]);
                fail_stop();
            end
            void'(exp_q.pop_front());
            frames_rx++;
        end
    endtask

    // i2s receiver, bits taken on rising bclk
    always @(posedge clk_soc) begin
        if (rx_en && !bclk_prev && ac_bclk_o) begin
            if (ac_lrclk_o != lr_prev) begin
                if (synced) begin
                    assert (pos == audio_pkg::SLOT_W - 1) else begin
                        $display("FAILED ac_lrclk_o slot length: got %h expected %h",
                                 pos + 1, audio_pkg::SLOT_W);
                        fail_stop();
                    end
                end
                if (ac_lrclk_o) synced = 1'b1;       // first right slot aligns us
                pos = 0;
            end else begin
                pos++;
            end
            lr_prev = ac_lrclk_o;
            if (synced) begin
                assert (pos < audio_pkg::SLOT_W) else begin
                    $display("slot ran past 32 bit clocks without an lrclk change");
                    fail_stop();
                end
                if (pos >= 1 && pos <= audio_pkg::SAMPLE_W) begin
                    cur_sample = {cur_sample[22:0], ac_dac_sdata_o};   // msb first
                end else begin
                    assert (!ac_dac_sdata_o) else begin
                        $display("FAILED ac_dac_sdata_o pad bit %0d: got %h expected %h",
                                 pos, ac_dac_sdata_o, 1'b0);
                        fail_stop();
                    end
                end
                if (pos == audio_pkg::SAMPLE_W && !ac_lrclk_o) left_rx = cur_sample;
                if (pos == audio_pkg::SAMPLE_W && ac_lrclk_o) check_frame({left_rx, cur_sample});
            end
        end
        bclk_prev = ac_bclk_o;
    end

    // mclk flips on every clk_soc edge once out of reset
    always @(posedge clk_soc) begin
        if (rx_en) begin
            assert (ac_mclk_o != mclk_prev) else begin
                $display("FAILED ac_mclk_o: got %h expected %h", ac_mclk_o, ~mclk_prev);
                fail_stop();
            end
        end
        mclk_prev = ac_mclk_o;
    end

    always @(posedge clk_soc) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the test did not complete", cycle_cnt);
            fail_stop();
        end
    end

    task automatic drain_then_idle();
        int z0;
        while (exp_q.size() != 0) @(posedge clk_soc);
        z0 = zero_frames;
        while (zero_frames < z0 + 2) @(posedge clk_soc);   // underflow sends silence
        read_check(soc_bus_pkg::REG_STATUS);
    endtask

    initial begin : main
        logic [31:0] r;
        logic [31:0] rd;
        int          lat;
        btn_rst  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        dip_i    = '0;
        btn_i    = '0;
        led_m = '0;
        dip_m = '0;
        btn_m = '0;
        exp_full  = 1'b0;
        exp_empty = 1'b1;
        repeat (4) @(posedge clk_soc);
        btn_rst <= 1'b0;
        repeat (RESET_CYCLES + 2) @(posedge clk_soc);
        assert (led_o == 8'h0 && !ac_lrclk_o && !ac_bclk_o && !ac_dac_sdata_o) else begin
            $display("FAILED reset outputs: led_o %h lrclk %h bclk %h sdata %h expected 0",
                     led_o, ac_lrclk_o, ac_bclk_o, ac_dac_sdata_o);
            fail_stop();
        end
        rx_en = 1'b1;
        read_check(soc_bus_pkg::REG_STATUS);
        repeat (8) begin                                   // led with mixed byte selects
            next_rand(r);
            wb_access(1'b1, soc_bus_pkg::REG_LED, r, r[11:8], rd, lat);
            if (r[8]) led_m = r[7:0];
            assert (led_o == led_m) else begin
                $display("FAILED led_o: got %h expected %h", led_o, led_m);
                fail_stop();
            end
            read_check(soc_bus_pkg::REG_LED);
        end
        repeat (4) begin
            next_rand(r);
            dip_i <= r[7:0];
            btn_i <= r[12:8];
            dip_m = r[7:0];
            btn_m = r[12:8];
            repeat (2) @(posedge clk_soc);                 // input sampling stage
            read_check(soc_bus_pkg::REG_DIP);
            read_check(soc_bus_pkg::REG_BTN);
        end
        read_check(4'd9);
        read_check(4'd14);
        read_check(soc_bus_pkg::REG_AUDIO_L);
        repeat (6) send_frame(lat);
        drain_then_idle();
        @(negedge ac_lrclk_o);                             // left slot just started
        @(posedge clk_soc);
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_frame(lat);
            if (i >= FIFO_DEPTH) begin
                assert (lat > 4) else begin
                    $display("right sample write acked although the fifo was full");
                    fail_stop();
                end
            end
        end
        exp_full  = 1'b1;
        exp_empty = 1'b0;
        read_check(soc_bus_pkg::REG_STATUS);
        exp_full  = 1'b0;
        exp_empty = 1'b1;
        drain_then_idle();
        assert (frames_rx == 8 + FIFO_DEPTH) else begin
            $display("FAILED frames_rx: got %h expected %h", frames_rx, 8 + FIFO_DEPTH);
            fail_stop();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== audio_periph_top.f ====
hdl/soc_bus_pkg.sv
hdl/audio_pkg.sv
hdl/reset_stretch.sv
hdl/wishbone_bus_logic.sv
hdl/audio_frame_fifo.sv
hdl/i2s_master.sv
hdl/audio_periph_top.sv
sim/tb_clock_gen.sv
sim/audio_periph_assert.sv
sim/tb_audio_periph.sv

// ==== Makefile ====
SRCS := $(shell cat audio_periph_top.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_audio_periph: audio_periph_top.f $(SRCS)
	verilator --binary --assert --top-module tb_audio_periph -f audio_periph_top.f -o Vtb_audio_periph

run: obj_dir/Vtb_audio_periph
	-./obj_dir/Vtb_audio_periph > sim.log 2>&1
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
